// ==== common/bus_pkg.sv ====
package bus_pkg;

    ////////////////////////////////////////
    // Z80 bus cycle events
    ////////////////////////////////////////

    // One-cycle strobe events from the synchronizer, plus the latched write byte
    typedef struct packed {
        logic       rd_start;   // Synchronized rd_n fell
        logic       rd_end;     // Synchronized rd_n rose
        logic       wr_start;   // Synchronized wr_n fell
        logic       wr_end;     // Synchronized wr_n rose
        logic [7:0] wrdata;     // Last byte seen while wr_n low
    } bus_event_t;

    ////////////////////////////////////////
    // Video port request
    ////////////////////////////////////////

    // Four-phase handshake payload, held stable while req is high
    typedef struct packed {
        logic       req;
        logic       write;      // 1 = write, 0 = read
        logic       port;       // 1 = control port, 0 = data port
        logic [7:0] wrdata;
    } vdp_req_t;

endpackage

// ==== common/map_pkg.sv ====
package map_pkg;

    ////////////////////////////////////////
    // I/O space
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        io_none,
        io_bank,        // $F0-$F3
        io_vdp_data,
        io_vdp_ctrl,
        io_joy1,
        io_joy2
    } io_port_e;

    // Upper six bits of the bank register ports
    localparam logic [5:0] io_bank_prefix = 6'b111100;

    ////////////////////////////////////////
    // Memory banking
    ////////////////////////////////////////

    typedef struct packed {
        logic       ro;         // Window is write protected
        logic       rsvd;       // Always reads back as 0
        logic [5:0] page;
    } bank_reg_t;

    // Window n maps page n after reset
    localparam logic [3:0][5:0] bank_reset_page = {6'd3, 6'd2, 6'd1, 6'd0};

endpackage

// ==== ebus/ebus_sync.sv ====
module ebus_sync (
    input  logic                clk,
    input  logic                reset,
    input  logic                rd_n,
    input  logic                wr_n,
    input  logic [7:0]          d_in,
    input  logic [7:0]          hc1,
    input  logic [7:0]          hc2,
    output bus_pkg::bus_event_t events,
    output logic [7:0]          joy1,
    output logic [7:0]          joy2
);

    logic [2:0]  rd_n_r;        // Bit 0 newest
    logic [2:0]  wr_n_r;
    logic [7:0]  wrdata_r;
    logic [15:0] hc_meta;
    logic [15:0] hc_sync;

    ////////////////////////////////////////
    // Strobe synchronizers
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_n_r <= 3'b111;   // Bus idle
            wr_n_r <= 3'b111;
        end else begin
            rd_n_r <= {rd_n_r[1:0], rd_n};
            wr_n_r <= {wr_n_r[1:0], wr_n};
        end
    end

    // Data is stable for the whole time the strobe is low
    always_ff @(posedge clk) begin
        if (!wr_n)
            wrdata_r <= d_in;
    end

    always_comb begin
        events.rd_start = (rd_n_r[2:1] == 2'b10);
        events.rd_end   = (rd_n_r[2:1] == 2'b01);
        events.wr_start = (wr_n_r[2:1] == 2'b10);
        events.wr_end   = (wr_n_r[2:1] == 2'b01);
        events.wrdata   = wrdata_r;
    end

    // Hand controllers, two flops each
    always_ff @(posedge clk) begin
        hc_meta <= {hc2, hc1};
        hc_sync <= hc_meta;
    end

    assign joy1 = hc_sync[7:0];
    assign joy2 = hc_sync[15:8];

    // Read and write strobes are never low together
    a_strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        rd_n_r[1] || wr_n_r[1]);

endmodule

// ==== ebus/ebus_decode.sv ====
module ebus_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic [15:0]         a,
    input  logic                mreq_n,
    input  logic                iorq_n,
    input  logic                rd_n,
    input  bus_pkg::bus_event_t events,
    input  logic [7:0]          ram_rddata,
    input  map_pkg::bank_reg_t  bank_rddata,
    input  logic [7:0]          vdp_rddata,
    input  logic [7:0]          joy1,
    input  logic [7:0]          joy2,
    input  logic                vdp_ack,
    output logic [7:0]          d_out,
    output logic                d_oe,
    output logic                ram_wr,
    output logic                bank_wr,
    output bus_pkg::vdp_req_t   vdp_req
);

    typedef enum logic [1:0] {hs_idle, hs_wait_ack, hs_wait_end, hs_release} hs_state_e;

    map_pkg::io_port_e io_port;
    hs_state_e         state;
    logic              sel_mem;
    logic              sel_vdp;
    logic              vdp_start;
    logic              vdp_end;
    logic              req_r;
    logic              write_r;
    logic              port_r;
    logic              end_seen;
    logic [7:0]        wrdata_r;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    assign sel_mem = !mreq_n;

    always_comb begin
        io_port = map_pkg::io_none;
        if (!iorq_n) begin
            if (a[7:2] == map_pkg::io_bank_prefix) begin
                io_port = map_pkg::io_bank;
            end else begin
                case ({a[7], a[6], a[0]})
                    3'b100:  io_port = map_pkg::io_vdp_data;
                    3'b101:  io_port = map_pkg::io_vdp_ctrl;
                    3'b110:  io_port = map_pkg::io_joy1;
                    3'b111:  io_port = map_pkg::io_joy2;
                    default: io_port = map_pkg::io_none;
                endcase
            end
        end
    end

    assign sel_vdp = (io_port == map_pkg::io_vdp_data) || (io_port == map_pkg::io_vdp_ctrl);
    assign d_oe    = !rd_n && (sel_mem || io_port != map_pkg::io_none);
    assign ram_wr  = events.wr_start && sel_mem;
    assign bank_wr = events.wr_start && (io_port == map_pkg::io_bank);

    // Read data mux
    always_comb begin
        d_out = 8'hFF;
        if (sel_mem) begin
            d_out = ram_rddata;
        end else begin
            case (io_port)
                map_pkg::io_bank:     d_out = bank_rddata;
                map_pkg::io_vdp_data: d_out = vdp_rddata;
                map_pkg::io_vdp_ctrl: d_out = vdp_rddata;
                map_pkg::io_joy1:     d_out = joy1;
                map_pkg::io_joy2:     d_out = joy2;
                default:              d_out = 8'hFF;
            endcase
        end
    end

    ////////////////////////////////////////
    // Video port req/ack master
    ////////////////////////////////////////

    assign vdp_start = sel_vdp && (events.wr_start || events.rd_start);
    assign vdp_end   = write_r ? events.wr_end : events.rd_end;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= hs_idle;
            req_r    <= 1'b0;
            write_r  <= 1'b0;
            port_r   <= 1'b0;
            end_seen <= 1'b0;
        end else begin
            case (state)
                hs_idle: begin
                    if (vdp_start && !vdp_ack) begin
                        req_r    <= 1'b1;
                        write_r  <= events.wr_start;
                        port_r   <= (io_port == map_pkg::io_vdp_ctrl);
                        end_seen <= 1'b0;
                        state    <= hs_wait_ack;
                    end
                end
                hs_wait_ack: begin
                    if (vdp_end)
                        end_seen <= 1'b1;   // Strobe may end before the ack
                    if (vdp_ack) begin
                        if (vdp_end || end_seen) begin
                            req_r <= 1'b0;
                            state <= hs_release;
                        end else begin
                            state <= hs_wait_end;
                        end
                    end
                end
                hs_wait_end: begin
                    if (vdp_end) begin
                        req_r <= 1'b0;
                        state <= hs_release;
                    end
                end
                hs_release: begin
                    if (!vdp_ack)
                        state <= hs_idle;
                end
                default: state <= hs_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == hs_idle && vdp_start)
            wrdata_r <= events.wrdata;
    end

    // Port follows the address while idle so the read value is ready early
    always_comb begin
        vdp_req.req    = req_r;
        vdp_req.write  = write_r;
        vdp_req.port   = (state == hs_idle) ? (io_port == map_pkg::io_vdp_ctrl) : port_r;
        vdp_req.wrdata = wrdata_r;
    end

    a_req_falls_after_ack: assert property (@(posedge clk) disable iff (reset)
        $fell(vdp_req.req) |-> $past(vdp_ack));

endmodule

// ==== logic/bank_regs.sv ====
module bank_regs #(
    parameter int ram_page_bits = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [15:0]              a,
    input  logic [7:0]               wrdata,
    input  logic                     bank_wr,
    output map_pkg::bank_reg_t       bank_rddata,
    output logic [ram_page_bits+13:0] ram_addr,
    output logic                     ram_ro
);

    map_pkg::bank_reg_t regs [4];   // I/O $F0-$F3
    map_pkg::bank_reg_t window;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i].ro   <= 1'b0;
                regs[i].rsvd <= 1'b0;
                regs[i].page <= map_pkg::bank_reset_page[i];
            end
        end else if (bank_wr) begin
            regs[a[1:0]] <= wrdata;
        end
    end

    // Read back of the addressed register
    always_comb begin
        bank_rddata      = regs[a[1:0]];
        bank_rddata.rsvd = 1'b0;
    end

    // Window select from the CPU address
    assign window   = regs[a[15:14]];
    assign ram_addr = {window.page[ram_page_bits-1:0], a[13:0]};
    assign ram_ro   = window.ro;

endmodule

// ==== logic/bank_ram.sv ====
module bank_ram #(
    parameter int ram_page_bits = 2
) (
    input  logic                      clk,
    input  logic [ram_page_bits+13:0] addr,
    input  logic [7:0]                wrdata,
    input  logic                      ram_wr,
    input  logic                      ram_ro,
    output logic [7:0]                rddata
);

    logic [7:0] mem [2**(ram_page_bits+14)];
    logic       wr_en;

    assign wr_en = ram_wr && !ram_ro;  // Protected windows drop the write

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[addr] <= wrdata;
        rddata <= mem[addr];
    end

    a_ro_write_blocked: assert property (@(posedge clk)
        (ram_wr && ram_ro) |=> mem[$past(addr)] === $past(mem[addr]));

endmodule

// ==== vdp/vdp_port.sv ====
module vdp_port #(
    parameter int vram_addr_bits = 14
) (
    input  logic              clk,
    input  logic              reset,
    input  bus_pkg::vdp_req_t vdp_req,
    output logic              vdp_ack,
    output logic [7:0]        vdp_rddata
);

    typedef enum logic [1:0] {vdp_idle, vdp_acked, vdp_finish} vdp_state_e;

    vdp_state_e                state;
    logic [7:0]                vram [2**vram_addr_bits];
    logic [vram_addr_bits-1:0] addr_r;
    logic                      latch_r;         // First control byte seen
    logic                      pend_prefetch;
    logic                      pend_clear;
    logic [7:0]                rd_buf;
    logic [7:0]                vram_q;
    logic [5:0]                addr_hi;
    logic                      data_wr;

    assign data_wr = (state == vdp_idle) && vdp_req.req && vdp_req.write && !vdp_req.port;
    assign addr_hi = 6'(addr_r[vram_addr_bits-1:8]);

    ////////////////////////////////////////
    // Handshake and address latch
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= vdp_idle;
            vdp_ack       <= 1'b0;
            addr_r        <= '0;
            latch_r       <= 1'b0;
            pend_prefetch <= 1'b0;
            pend_clear    <= 1'b0;
        end else begin
            case (state)
                vdp_idle: begin
                    if (vdp_req.req) begin
                        vdp_ack <= 1'b1;
                        state   <= vdp_acked;
                        if (vdp_req.write && vdp_req.port) begin
                            if (!latch_r) begin
                                addr_r[7:0] <= vdp_req.wrdata;  // Low byte first
                                latch_r     <= 1'b1;
                            end else begin
                                addr_r[vram_addr_bits-1:8] <= vdp_req.wrdata[vram_addr_bits-9:0];
                                latch_r       <= 1'b0;
                                pend_prefetch <= !vdp_req.wrdata[6];  // Read setup
                            end
                        end else if (vdp_req.write) begin
                            addr_r <= addr_r + 1'b1;
                        end else if (vdp_req.port) begin
                            pend_clear <= 1'b1;
                        end else begin
                            pend_prefetch <= 1'b1;
                        end
                    end
                end
                vdp_acked: begin
                    if (!vdp_req.req)
                        state <= vdp_finish;
                end
                vdp_finish: begin
                    // Read side effects happen once the master has let go
                    if (pend_prefetch)
                        addr_r <= addr_r + 1'b1;
                    if (pend_clear)
                        latch_r <= 1'b0;
                    pend_prefetch <= 1'b0;
                    pend_clear    <= 1'b0;
                    vdp_ack       <= 1'b0;
                    state         <= vdp_idle;
                end
                default: state <= vdp_idle;
            endcase
        end
    end

    ////////////////////////////////////////
    // VRAM and read buffer
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (data_wr)
            vram[addr_r] <= vdp_req.wrdata;
        vram_q <= vram[addr_r];
    end

    always_ff @(posedge clk) begin
        if (data_wr)
            rd_buf <= vdp_req.wrdata;
        else if (state == vdp_finish && pend_prefetch)
            rd_buf <= vram_q;
    end

    assign vdp_rddata = vdp_req.port ? {latch_r, 1'b0, addr_hi} : rd_buf;

    // Master holds the payload while req is high
    a_payload_stable: assert property (@(posedge clk) disable iff (reset)
        vdp_req.req && $past(vdp_req.req) |->
            $stable(vdp_req.write) && $stable(vdp_req.port) && $stable(vdp_req.wrdata));

endmodule

// ==== logic/console_core.sv ====
module console_core #(
    parameter int ram_page_bits  = 2,
    parameter int vram_addr_bits = 14
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic        mreq_n,
    input  logic        iorq_n,
    input  logic [15:0] a,
    input  logic [7:0]  d_in,
    input  logic [7:0]  hc1,
    input  logic [7:0]  hc2,
    output logic [7:0]  d_out,
    output logic        d_oe
);

    bus_pkg::bus_event_t       events;
    bus_pkg::vdp_req_t         vdp_req;
    map_pkg::bank_reg_t        bank_rddata;
    logic [7:0]                joy1;
    logic [7:0]                joy2;
    logic [7:0]                ram_rddata;
    logic [7:0]                vdp_rddata;
    logic                      vdp_ack;
    logic                      ram_wr;
    logic                      bank_wr;
    logic                      ram_ro;
    logic [ram_page_bits+13:0] ram_addr;

    ////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////

    ebus_sync ebus_sync (
        .clk(clk), .reset(reset),
        .rd_n(rd_n), .wr_n(wr_n), .d_in(d_in),
        .hc1(hc1), .hc2(hc2),
        .events(events), .joy1(joy1), .joy2(joy2));

    ebus_decode ebus_decode (
        .clk(clk), .reset(reset),
        .a(a), .mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n),
        .events(events),
        .ram_rddata(ram_rddata), .bank_rddata(bank_rddata),
        .vdp_rddata(vdp_rddata), .joy1(joy1), .joy2(joy2),
        .vdp_ack(vdp_ack),
        .d_out(d_out), .d_oe(d_oe),
        .ram_wr(ram_wr), .bank_wr(bank_wr), .vdp_req(vdp_req));

    ////////////////////////////////////////
    // Banked memory and video
    ////////////////////////////////////////

    bank_regs #(.ram_page_bits(ram_page_bits)) bank_regs (
        .clk(clk), .reset(reset),
        .a(a), .wrdata(events.wrdata), .bank_wr(bank_wr),
        .bank_rddata(bank_rddata), .ram_addr(ram_addr), .ram_ro(ram_ro));

    bank_ram #(.ram_page_bits(ram_page_bits)) bank_ram (
        .clk(clk),
        .addr(ram_addr), .wrdata(events.wrdata),
        .ram_wr(ram_wr), .ram_ro(ram_ro),
        .rddata(ram_rddata));

    vdp_port #(.vram_addr_bits(vram_addr_bits)) vdp_port (
        .clk(clk), .reset(reset),
        .vdp_req(vdp_req),
        .vdp_ack(vdp_ack), .vdp_rddata(vdp_rddata));

endmodule

// ==== test/tb_bus_tasks.svh ====
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

////////////////////////////////////////
// Z80 bus cycles
////////////////////////////////////////

// Strobe low for 6 clocks, read data sampled in the 5th, then 4 idle clocks
task automatic bus_cycle(input logic io, input logic write, input logic [15:0] addr,
                         input logic [7:0] data, input logic [7:0] expect_d,
                         input logic hit);
    @(posedge clk);
    a       <= addr;
    d_in    <= data;
    mreq_n  <= io;
    iorq_n  <= !io;
    exp_d   <= expect_d;
    bus_hit <= hit;
    @(posedge clk);
    if (write)
        wr_n <= 1'b0;
    else
        rd_n <= 1'b0;
    repeat (4) @(posedge clk);
    if (!write) begin
        check_rd <= 1'b1;   // Sampled on the next edge
        checks = checks + 1;
    end
    @(posedge clk);
    check_rd <= 1'b0;
    @(posedge clk);
    rd_n <= 1'b1;
    wr_n <= 1'b1;
    @(posedge clk);
    mreq_n  <= 1'b1;
    iorq_n  <= 1'b1;
    bus_hit <= 1'b0;
    @(posedge clk);
endtask

task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
    if (!bank_model[addr[15:14]][7])
        ram_model[phys_addr(addr)] = data;
    bus_cycle(1'b0, 1'b1, addr, data, 8'h00, 1'b1);
endtask

task automatic mem_read(input logic [15:0] addr);
    bus_cycle(1'b0, 1'b0, addr, 8'h00, ram_model[phys_addr(addr)], 1'b1);
endtask

task automatic io_write(input logic [7:0] port, input logic [7:0] data);
    apply_io_write(port, data);
    bus_cycle(1'b1, 1'b1, {8'h00, port}, data, 8'h00, io_hits(port));
endtask

task automatic io_read(input logic [7:0] port);
    logic [7:0] value;
    predict_io_read(port, value);
    bus_cycle(1'b1, 1'b0, {8'h00, port}, 8'h00, value, io_hits(port));
endtask

// 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

`endif

// ==== test/tb_console_core.sv ====
module tb_console_core;

    localparam int clk_period    = 40;
    localparam int page_bits     = 2;
    localparam int vram_bits     = 14;
    localparam int bus_cycles    = 86;     // Sum over all tests below
    localparam int margin_clocks = 100;

    logic        clk = 1'b0;
    logic        reset;
    logic        rd_n;
    logic        wr_n;
    logic        mreq_n;
    logic        iorq_n;
    logic [15:0] a;
    logic [7:0]  d_in;
    logic [7:0]  hc1;
    logic [7:0]  hc2;
    logic [7:0]  d_out;
    logic        d_oe;

    logic        check_rd = 1'b0;
    logic        bus_hit = 1'b0;
    logic [7:0]  exp_d = 8'h00;
    logic [31:0] rng = 32'h389e;
    int          errors = 0;
    int          errors_before = 0;
    int          checks = 0;
    int          tests_run = 0;

    // Reference model
    logic [7:0]           ram_model [2**(page_bits+14)];
    logic [7:0]           bank_model [4];
    logic [7:0]           vram_model [2**vram_bits];
    logic [vram_bits-1:0] vaddr;
    logic [7:0]           vbuf;
    logic                 vlatch;

    console_core #(.ram_page_bits(page_bits), .vram_addr_bits(vram_bits)) UUT (
        .clk(clk), .reset(reset),
        .rd_n(rd_n), .wr_n(wr_n), .mreq_n(mreq_n), .iorq_n(iorq_n),
        .a(a), .d_in(d_in), .hc1(hc1), .hc2(hc2),
        .d_out(d_out), .d_oe(d_oe));

    always #(clk_period / 2) clk = ~clk;

    ////////////////////////////////////////
    // Model of the memory and I/O map
    ////////////////////////////////////////

    function automatic logic [page_bits+13:0] phys_addr(input logic [15:0] addr);
        return {bank_model[addr[15:14]][page_bits-1:0], addr[13:0]};
    endfunction

    function automatic logic io_hits(input logic [7:0] port);
        return (port[7:2] == 6'b111100) || port[7];   // Every VDP and joystick port has a7 set
    endfunction

    task automatic apply_io_write(input logic [7:0] port, input logic [7:0] data);
        if (port[7:2] == 6'b111100) begin
            bank_model[port[1:0]] = data;
        end else if ({port[7], port[6], port[0]} == 3'b100) begin
            vram_model[vaddr] = data;
            vbuf  = data;
            vaddr = vaddr + 1'b1;
        end else if ({port[7], port[6], port[0]} == 3'b101) begin
            if (!vlatch) begin
                vaddr[7:0] = data;
                vlatch     = 1'b1;
            end else begin
                vaddr[vram_bits-1:8] = data[5:0];
                vlatch = 1'b0;
                if (!data[6]) begin   // Read setup prefetches
                    vbuf  = vram_model[vaddr];
                    vaddr = vaddr + 1'b1;
                end
            end
        end
    endtask

    task automatic predict_io_read(input logic [7:0] port, output logic [7:0] value);
        if (port[7:2] == 6'b111100) begin
            value = bank_model[port[1:0]] & 8'hBF;
        end else begin
            case ({port[7], port[6], port[0]})
                3'b100: begin
                    value = vbuf;
                    vbuf  = vram_model[vaddr];
                    vaddr = vaddr + 1'b1;
                end
                3'b101: begin
                    value  = {vlatch, 1'b0, vaddr[vram_bits-1:8]};
                    vlatch = 1'b0;
                end
                3'b110:  value = hc1;
                3'b111:  value = hc2;
                default: value = 8'hFF;
            endcase
        end
    endtask

    function automatic logic [31:0] draw_random();
        rng = xorshift(rng);
        return rng;
    endfunction

    `include "tb_bus_tasks.svh"

    task automatic report_test(input string name);
        tests_run = tests_run + 1;
        if (errors == errors_before)
            $display("test %0d %s: ok", tests_run, name);
        else
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        errors_before = errors;
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_read_data: assert property (@(posedge clk) disable iff (reset) check_rd |-> d_out === exp_d)
        else begin
            errors = errors + 1;
            $display("error: d_out = %h, expected %h, address %h",
                     $sampled(d_out), $sampled(exp_d), $sampled(a));
        end

    // Output enable only on a read that hits
    a_output_enable: assert property (@(posedge clk) disable iff (reset)
        d_oe === (!rd_n && bus_hit))
        else begin
            errors = errors + 1;
            $display("error: d_oe = %h, expected %h, address %h",
                     $sampled(d_oe), $sampled(!rd_n && bus_hit), $sampled(a));
        end

    initial begin
        #(clk_period * (bus_cycles * 10 + margin_clocks));
        $display("watchdog: tests did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    initial begin
        logic [15:0] addrs [16];
        logic [13:0] off;
        logic [13:0] vbase;
        logic [7:0]  old_byte;
        logic [31:0] r;

        reset  = 1'b1;
        rd_n   = 1'b1;
        wr_n   = 1'b1;
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        a      = 16'h0000;
        d_in   = 8'h00;
        hc1    = 8'h00;
        hc2    = 8'h00;
        for (int i = 0; i < 4; i++)
            bank_model[i] = 8'(i);
        vaddr  = '0;
        vbuf   = 8'h00;
        vlatch = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        for (int p = 0; p < 4; p++)
            io_read(8'(8'hF0 + p));
        io_read(8'h10);
        report_test("reset values");

        for (int k = 0; k < 16; k++) begin
            addrs[k] = {2'(k / 4), 14'(draw_random())};   // Four per window
            mem_write(addrs[k], 8'(draw_random()));
        end
        for (int k = 0; k < 16; k++)
            mem_read(addrs[k]);
        off = 14'(draw_random());
        io_write(8'hF3, 8'h00);
        mem_write({2'b00, off}, 8'(draw_random()));
        mem_read({2'b11, off});   // Window 3 now aliases window 0
        report_test("bank windows");

        off      = 14'(draw_random());
        old_byte = 8'(draw_random());
        mem_write({2'b01, off}, old_byte);
        io_write(8'hF1, 8'hC1);
        io_read(8'hF1);
        mem_write({2'b01, off}, ~old_byte);
        mem_read({2'b01, off});
        io_write(8'hF2, 8'h01);
        mem_write({2'b10, off}, ~old_byte);
        mem_read({2'b01, off});
        mem_read({2'b10, off});
        io_write(8'hF1, 8'h01);
        io_write(8'hF2, 8'h02);
        report_test("read-only bank");

        vbase = 14'(draw_random());
        io_write(8'h81, vbase[7:0]);
        io_write(8'h81, {2'b01, vbase[13:8]});
        for (int k = 0; k < 8; k++)
            io_write(8'h80, 8'(draw_random()));
        io_write(8'h81, vbase[7:0]);
        io_write(8'h81, {2'b00, vbase[13:8]});
        for (int k = 0; k < 8; k++)
            io_read(8'h80);
        io_write(8'h81, 8'(draw_random()));
        io_read(8'h81);   // Latch flag still set
        io_read(8'h81);
        report_test("video port");

        for (int k = 0; k < 4; k++) begin
            r = draw_random();
            @(posedge clk);
            hc1 <= r[7:0];
            hc2 <= r[15:8];
            repeat (2) @(posedge clk);
            io_read(8'hC0);
            io_read(8'hC1);
        end
        report_test("hand controllers");

        io_read(8'h3E);
        io_write(8'h10, 8'(draw_random()));
        mem_write(16'h2000, 8'(draw_random()));
        mem_read(16'h2000);
        repeat (10) @(posedge clk);
        report_test("output enable");

        $display("%0d tests, %0d read checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+test
common/bus_pkg.sv
common/map_pkg.sv
ebus/ebus_sync.sv
ebus/ebus_decode.sv
logic/bank_regs.sv
logic/bank_ram.sv
vdp/vdp_port.sv
logic/console_core.sv
test/tb_console_core.sv

// ==== Bender.yml ====
package:
  name: console_core

sources:
  - common/bus_pkg.sv
  - common/map_pkg.sv
  - ebus/ebus_sync.sv
  - ebus/ebus_decode.sv
  - logic/bank_regs.sv
  - logic/bank_ram.sv
  - vdp/vdp_port.sv
  - logic/console_core.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_console_core.sv
